// File: filelist.f
hw/dmem_pkg.sv
hw/axil_dmem_slave.sv
hw/lane_router.sv
hw/byte_bank.sv
hw/lane_merger.sv
hw/dmem_top.sv
tb/tb_dmem.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_dmem
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/tb_dmem.sv
`timescale 1ns/1ps

module tb_dmem;
    import dmem_pkg::*;

    localparam logic [31:0] SEED = 32'hfc21_8758;
    localparam int TIMEOUT_CYCLES = 300 * 12 + 400;     // Worst case per transaction plus margin

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic awvalid, wvalid, arvalid, bready, rready;
    logic awready, wready, arready, bvalid, rvalid;
    logic [ADDR_W-1:0] awaddr, araddr, dbg_addr;
    logic [DATA_W-1:0] wdata, rdata, dbg_data, exp_dbg;
    logic [LANES-1:0] wstrb;
    logic [1:0] bresp, rresp;
    logic [7:0] model [MEM_BYTES];                      // Byte image of the memory
    logic [31:0] seed;
    logic dbg_armed = 1'b0;
    int n_errors = 0;
    int n_tests = 0;
    int cycle_count = 0;

    dmem_top DUT (
        .clk(clk), .rst(rst),
        .i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr),
        .i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata), .i_wstrb(wstrb),
        .o_bvalid(bvalid), .i_bready(bready), .o_bresp(bresp),
        .i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr),
        .o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata), .o_rresp(rresp),
        .i_dbg_addr(dbg_addr), .o_dbg_data(dbg_data)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        seed = xorshift(seed);
        return seed;
    endfunction

    // Little-endian word from any start byte with wrap past the last byte
    function automatic logic [DATA_W-1:0] model_word(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] w;
        for (int k = 0; k < LANES; k++) begin
            w[8*k +: 8] = model[addr + ADDR_W'(k)];
        end
        return w;
    endfunction

    function automatic void report_mismatch(input string name, input logic [DATA_W-1:0] got,
                                            input logic [DATA_W-1:0] exp);
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        n_errors++;
    endfunction

    function automatic void report_failure(input string what);
        $display("error at %0t: %s", $time, what);
        n_errors++;
    endfunction

    function automatic void finish_test(input string name, input int start);
        n_tests++;
        $display("test %0d %-12s %0d errors", n_tests, name, n_errors - start);
    endfunction

    // Memory and model both return to all zero
    task automatic apply_reset();
        for (int i = 0; i < MEM_BYTES; i++) begin
            model[i] = 8'h00;
        end
        dbg_armed = 1'b0;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        dbg_armed = 1'b1;
    endtask

    // Response waits for delay cycles while new requests are offered and must stay unanswered
    task automatic hold_response(input int delay, input logic is_read,
                                 input logic [DATA_W-1:0] exp);
        for (int i = 0; i <= delay; i++) begin
            @(posedge clk);
            #1;
            {awvalid, wvalid, arvalid} = (i < delay) ? 3'b111 : 3'b000;
            {rready, bready} = (i < delay) ? 2'b00 : {is_read, !is_read};
            @(negedge clk);
            if (is_read) begin
                assert (rvalid) else report_failure("RVALID dropped before RREADY");
                assert (rdata == exp) else report_mismatch("o_rdata", rdata, exp);
            end else begin
                assert (bvalid) else report_failure("BVALID dropped before BREADY");
            end
        end
        @(posedge clk);
        #1;
        {rready, bready} = 2'b00;
    endtask

    task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [LANES-1:0] strb, input int delay);
        awaddr = addr;
        wdata = data;
        wstrb = strb;
        {awvalid, wvalid} = 2'b11;
        do begin
            @(negedge clk);
        end while (!(awready && wready));
        @(posedge clk);
        #1;
        {awvalid, wvalid} = 2'b00;
        for (int k = 0; k < LANES; k++) begin
            if (strb[k]) begin
                model[addr + ADDR_W'(k)] = data[8*k +: 8];     // Strobe k enables addr + k
            end
        end
        @(negedge clk);
        assert (bvalid && bresp == 2'b00) else report_failure("no OKAY response after write");
        hold_response(delay, 1'b0, '0);
    endtask

    task automatic axi_read(input logic [ADDR_W-1:0] addr, input int delay);
        logic [DATA_W-1:0] exp;
        araddr = addr;
        arvalid = 1'b1;
        do begin
            @(negedge clk);
        end while (!arready);
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        exp = model_word(addr);
        @(negedge clk);
        assert (rvalid && rresp == 2'b00) else report_failure("no OKAY response after read");
        assert (rdata == exp) else report_mismatch("o_rdata", rdata, exp);
        hold_response(delay, 1'b1, exp);
    endtask

    // Model as seen at the edge before that edge's write lands
    always @(posedge clk) begin
        exp_dbg <= model_word(dbg_addr);
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    a_dbg_word: assert property (@(negedge clk) disable iff (!dbg_armed)
        dbg_data == exp_dbg) else report_mismatch("o_dbg_data", dbg_data, exp_dbg);

    a_wresp_blocks: assert property (@(negedge clk) disable iff (rst)
        bvalid |-> !(awready || wready || arready))
        else report_failure("handshake accepted while BVALID pending");

    a_rresp_blocks: assert property (@(negedge clk) disable iff (rst)
        rvalid |-> !(awready || wready || arready))
        else report_failure("handshake accepted while RVALID pending");

    initial begin
        logic [31:0] r;
        logic [ADDR_W-1:0] odd_addrs [6];
        logic [LANES-1:0] fixed_strb [4];
        int start;
        seed = SEED;
        {awvalid, wvalid, arvalid, bready, rready} = '0;
        awaddr = '0;
        araddr = '0;
        dbg_addr = '0;
        wdata = '0;
        wstrb = '0;
        odd_addrs = '{6'd1, 6'd2, 6'd3, 6'd61, 6'd62, 6'd63};
        fixed_strb = '{4'h1, 4'h3, 4'h7, 4'hf};
        apply_reset();

        start = n_errors;
        for (int i = 0; i < MEM_BYTES / LANES; i++) begin
            axi_write(ADDR_W'(4 * i), 32'hffff_ffff, 4'hf, 0);    // Every byte nonzero
        end
        apply_reset();
        @(negedge clk);
        assert (!(awready || wready || arready || bvalid || rvalid))
            else report_failure("ready or valid output high after reset");
        @(posedge clk);
        #1;
        for (int a = 0; a < MEM_BYTES; a++) begin
            axi_read(ADDR_W'(a), 0);
        end
        finish_test("reset", start);

        start = n_errors;
        for (int i = 0; i < MEM_BYTES / LANES; i++) begin
            axi_write(ADDR_W'(4 * i), next_rand(), 4'hf, 0);
        end
        for (int i = 0; i < MEM_BYTES / LANES; i++) begin
            axi_read(ADDR_W'(4 * i), 0);
        end
        finish_test("aligned", start);

        start = n_errors;
        foreach (odd_addrs[i]) begin
            axi_write(odd_addrs[i], next_rand(), 4'hf, 0);
            axi_read(odd_addrs[i], 0);
        end
        foreach (odd_addrs[i]) begin
            axi_read(odd_addrs[i], 0);                  // Overlapping writes seen in order
        end
        finish_test("unaligned", start);

        start = n_errors;
        foreach (fixed_strb[i]) begin
            r = next_rand();
            axi_write(r[5:0], next_rand(), fixed_strb[i], 0);
            axi_read(r[5:0], 0);
        end
        repeat (20) begin
            r = next_rand();
            axi_write(r[5:0], next_rand(), r[11:8], 0);
            axi_read(r[5:0], 0);
        end
        finish_test("strobes", start);

        start = n_errors;
        repeat (30) begin
            r = next_rand();
            if (r[16]) begin
                axi_write(r[5:0], next_rand(), r[11:8], 1 + int'(r[14:12]));
            end else begin
                axi_read(r[5:0], 1 + int'(r[14:12]));
            end
        end
        finish_test("backpressure", start);

        start = n_errors;
        for (int a = 0; a < MEM_BYTES; a++) begin
            dbg_addr = ADDR_W'(a);
            @(posedge clk);
            #1;
        end
        repeat (40) begin
            r = next_rand();
            dbg_addr = r[21:16];                        // Often hits the row being written
            if (r[24]) begin
                axi_write(r[5:0], next_rand(), r[11:8], int'(r[13:12]));
            end else begin
                axi_read(r[5:0], int'(r[13:12]));
            end
        end
        repeat (4) @(posedge clk);
        #1;
        finish_test("debug", start);

        $display("tests run %0d, errors %0d", n_tests, n_errors);
        if (n_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: hw/dmem_top.sv
`timescale 1ns/1ps

module dmem_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_awvalid,
    output logic                         o_awready,
    input  logic [dmem_pkg::ADDR_W-1:0]  i_awaddr,
    input  logic                         i_wvalid,
    output logic                         o_wready,
    input  logic [dmem_pkg::DATA_W-1:0]  i_wdata,
    input  logic [dmem_pkg::LANES-1:0]   i_wstrb,
    output logic                         o_bvalid,
    input  logic                         i_bready,
    output logic [1:0]                   o_bresp,
    input  logic                         i_arvalid,
    output logic                         o_arready,
    input  logic [dmem_pkg::ADDR_W-1:0]  i_araddr,
    output logic                         o_rvalid,
    input  logic                         i_rready,
    output logic [dmem_pkg::DATA_W-1:0]  o_rdata,
    output logic [1:0]                   o_rresp,
    input  logic [dmem_pkg::ADDR_W-1:0]  i_dbg_addr,
    output logic [dmem_pkg::DATA_W-1:0]  o_dbg_data
);
    import dmem_pkg::*;

    logic                         wr_en;
    logic [ADDR_W-1:0]            wr_addr;
    dmem_word_u                   wr_data;
    logic [LANES-1:0]             wr_strb;
    logic                         rd_en;
    logic [ADDR_W-1:0]            rd_addr;
    dmem_word_u                   rd_word;
    dmem_word_u                   dbg_word;
    logic [LANES-1:0]             bank_we;
    logic [LANES-1:0][ROW_W-1:0]  bank_wrow;
    logic [LANES-1:0][7:0]        bank_wbyte;
    logic [LANES-1:0][ROW_W-1:0]  bank_rrow;
    logic [LANES-1:0][ROW_W-1:0]  bank_drow;
    logic [LANES-1:0][7:0]        rbytes;
    logic [LANES-1:0][7:0]        dbytes;
    logic [LANE_W-1:0]            rd_lane;
    logic [LANE_W-1:0]            dbg_lane;

    axil_dmem_slave u_slave (
        .clk(clk), .rst(rst),
        .i_awvalid(i_awvalid), .o_awready(o_awready), .i_awaddr(i_awaddr),
        .i_wvalid(i_wvalid), .o_wready(o_wready), .i_wdata(i_wdata), .i_wstrb(i_wstrb),
        .o_bvalid(o_bvalid), .i_bready(i_bready), .o_bresp(o_bresp),
        .i_arvalid(i_arvalid), .o_arready(o_arready), .i_araddr(i_araddr),
        .o_rvalid(o_rvalid), .i_rready(i_rready), .o_rdata(o_rdata), .o_rresp(o_rresp),
        .o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_data(wr_data), .o_wr_strb(wr_strb),
        .o_rd_en(rd_en), .o_rd_addr(rd_addr), .i_rd_data(rd_word)
    );

    lane_router u_router (
        .clk(clk), .rst(rst),
        .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data), .i_wr_strb(wr_strb),
        .i_rd_addr(rd_addr), .i_dbg_addr(i_dbg_addr),
        .o_bank_we(bank_we), .o_bank_wrow(bank_wrow), .o_bank_wbyte(bank_wbyte),
        .o_bank_rrow(bank_rrow), .o_bank_drow(bank_drow),
        .o_rd_lane(rd_lane), .o_dbg_lane(dbg_lane)
    );

    for (genvar b = 0; b < LANES; b++) begin : g_bank
        byte_bank u_bank (
            .clk(clk), .rst(rst),
            .i_we(bank_we[b]), .i_wrow(bank_wrow[b]), .i_wbyte(bank_wbyte[b]),
            .i_rd_en(rd_en),                                // Same read strobe for all banks
            .i_rrow(bank_rrow[b]), .i_drow(bank_drow[b]),
            .o_rbyte(rbytes[b]), .o_dbyte(dbytes[b])
        );
    end

    lane_merger u_merger (
        .i_rbytes(rbytes), .i_dbytes(dbytes),
        .i_rd_lane(rd_lane), .i_dbg_lane(dbg_lane),
        .o_rd_word(rd_word), .o_dbg_word(dbg_word)
    );

    assign o_dbg_data = dbg_word.word;

endmodule

// File: hw/lane_merger.sv
`timescale 1ns/1ps

module lane_merger (
    input  logic [dmem_pkg::LANES-1:0][7:0]  i_rbytes,
    input  logic [dmem_pkg::LANES-1:0][7:0]  i_dbytes,
    input  logic [dmem_pkg::LANE_W-1:0]      i_rd_lane,
    input  logic [dmem_pkg::LANE_W-1:0]      i_dbg_lane,
    output dmem_pkg::dmem_word_u             o_rd_word,
    output dmem_pkg::dmem_word_u             o_dbg_word
);
    import dmem_pkg::*;

    // Byte k of the word sits in bank (lane + k) mod 4
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            o_rd_word.bytes[k]  = i_rbytes[LANE_W'(k) + i_rd_lane];
            o_dbg_word.bytes[k] = i_dbytes[LANE_W'(k) + i_dbg_lane];
        end
    end

endmodule

// File: hw/byte_bank.sv
`timescale 1ns/1ps

module byte_bank (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_we,
    input  logic [dmem_pkg::ROW_W-1:0]  i_wrow,
    input  logic [7:0]                  i_wbyte,
    input  logic                        i_rd_en,
    input  logic [dmem_pkg::ROW_W-1:0]  i_rrow,
    input  logic [dmem_pkg::ROW_W-1:0]  i_drow,
    output logic [7:0]                  o_rbyte,
    output logic [7:0]                  o_dbyte
);
    import dmem_pkg::*;

    logic [7:0] mem [ROWS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < ROWS; r++) begin
                mem[r] <= 8'h00;                 // Whole bank cleared on one edge
            end
        end else if (i_we) begin
            mem[i_wrow] <= i_wbyte;
        end
    end

    // Access read holds between reads, debug read tracks every cycle
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rbyte <= mem[i_rrow];
        end
        o_dbyte <= mem[i_drow];
    end

endmodule

// File: hw/lane_router.sv
`timescale 1ns/1ps

module lane_router (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             i_wr_en,
    input  logic [dmem_pkg::ADDR_W-1:0]                      i_wr_addr,
    input  dmem_pkg::dmem_word_u                             i_wr_data,
    input  logic [dmem_pkg::LANES-1:0]                       i_wr_strb,
    input  logic [dmem_pkg::ADDR_W-1:0]                      i_rd_addr,
    input  logic [dmem_pkg::ADDR_W-1:0]                      i_dbg_addr,
    output logic [dmem_pkg::LANES-1:0]                       o_bank_we,
    output logic [dmem_pkg::LANES-1:0][dmem_pkg::ROW_W-1:0]  o_bank_wrow,
    output logic [dmem_pkg::LANES-1:0][7:0]                  o_bank_wbyte,
    output logic [dmem_pkg::LANES-1:0][dmem_pkg::ROW_W-1:0]  o_bank_rrow,
    output logic [dmem_pkg::LANES-1:0][dmem_pkg::ROW_W-1:0]  o_bank_drow,
    output logic [dmem_pkg::LANE_W-1:0]                      o_rd_lane,
    output logic [dmem_pkg::LANE_W-1:0]                      o_dbg_lane
);
    import dmem_pkg::*;

    logic [LANE_W-1:0] wr_lane;

    // Banks below the start lane hold bytes that spill into the next row
    function automatic logic [ROW_W-1:0] bank_row(input logic [ADDR_W-1:0] addr,
                                                  input logic [LANE_W-1:0] bank);
        return addr[ADDR_W-1:LANE_W] + ROW_W'(bank < addr[LANE_W-1:0]);
    endfunction

    assign wr_lane = i_wr_addr[LANE_W-1:0];

    always_comb begin
        for (int b = 0; b < LANES; b++) begin
            // Bank b carries byte (b - start) mod 4 of the word
            o_bank_we[b]    = i_wr_en & i_wr_strb[LANE_W'(b) - wr_lane];
            o_bank_wbyte[b] = i_wr_data.bytes[LANE_W'(b) - wr_lane];
            o_bank_wrow[b]  = bank_row(i_wr_addr, LANE_W'(b));
            o_bank_rrow[b]  = bank_row(i_rd_addr, LANE_W'(b));
            o_bank_drow[b]  = bank_row(i_dbg_addr, LANE_W'(b));
        end
    end

    // Offsets follow the bank read registers by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            o_rd_lane  <= '0;
            o_dbg_lane <= '0;
        end else begin
            o_rd_lane  <= i_rd_addr[LANE_W-1:0];
            o_dbg_lane <= i_dbg_addr[LANE_W-1:0];
        end
    end

    // Rotation moves each enabled strobe onto exactly one bank
    a_we_matches_strb: assert property (@(posedge clk) disable iff (rst)
        $countones(o_bank_we) == (i_wr_en ? $countones(i_wr_strb) : 0));

endmodule

// File: hw/axil_dmem_slave.sv
`timescale 1ns/1ps

module axil_dmem_slave (
    input  logic                         clk,
    input  logic                         rst,
    // Write address and data
    input  logic                         i_awvalid,
    output logic                         o_awready,
    input  logic [dmem_pkg::ADDR_W-1:0]  i_awaddr,
    input  logic                         i_wvalid,
    output logic                         o_wready,
    input  logic [dmem_pkg::DATA_W-1:0]  i_wdata,
    input  logic [dmem_pkg::LANES-1:0]   i_wstrb,
    // Write response
    output logic                         o_bvalid,
    input  logic                         i_bready,
    output logic [1:0]                   o_bresp,
    // Read address
    input  logic                         i_arvalid,
    output logic                         o_arready,
    input  logic [dmem_pkg::ADDR_W-1:0]  i_araddr,
    // Read data
    output logic                         o_rvalid,
    input  logic                         i_rready,
    output logic [dmem_pkg::DATA_W-1:0]  o_rdata,
    output logic [1:0]                   o_rresp,
    // Memory side
    output logic                         o_wr_en,
    output logic [dmem_pkg::ADDR_W-1:0]  o_wr_addr,
    output dmem_pkg::dmem_word_u         o_wr_data,
    output logic [dmem_pkg::LANES-1:0]   o_wr_strb,
    output logic                         o_rd_en,
    output logic [dmem_pkg::ADDR_W-1:0]  o_rd_addr,
    input  dmem_pkg::dmem_word_u         i_rd_data
);
    import dmem_pkg::*;

    logic [STATE_W-1:0] state;
    logic [ADDR_W-1:0]  rd_addr_q;
    logic               idle;
    logic               wr_go;
    logic               rd_go;

    assign idle  = (state == ST_IDLE);
    assign wr_go = idle && i_awvalid && i_wvalid;          // Both halves of a write present
    assign rd_go = idle && i_arvalid && !(i_awvalid && i_wvalid);

    // Readies follow the valids and stay low while nothing is offered
    assign o_awready = wr_go;
    assign o_wready  = wr_go;
    assign o_arready = rd_go;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (wr_go) begin
                        state <= ST_WRESP;
                    end else if (rd_go) begin
                        state <= ST_RRESP;
                    end
                end
                ST_WRESP: begin
                    if (i_bready) begin
                        state <= ST_IDLE;
                    end
                end
                ST_RRESP: begin
                    if (i_rready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Read address kept for the lane offset while RVALID waits
    always_ff @(posedge clk) begin
        if (rd_go) begin
            rd_addr_q <= i_araddr;
        end
    end

    assign o_wr_en        = wr_go;                         // Banks write at the handshake edge
    assign o_wr_addr      = i_awaddr;
    assign o_wr_data.word = i_wdata;
    assign o_wr_strb      = i_wstrb;
    assign o_rd_en        = rd_go;                         // Banks capture at the AR edge
    assign o_rd_addr      = idle ? i_araddr : rd_addr_q;

    assign o_bvalid = (state == ST_WRESP);
    assign o_bresp  = RESP_OKAY;
    assign o_rvalid = (state == ST_RRESP);
    assign o_rdata  = i_rd_data.word;                      // Banks hold it until the next read
    assign o_rresp  = RESP_OKAY;

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        o_bvalid && !i_bready |=> o_bvalid);

    // Bank registers and router lane offsets together keep RDATA still
    a_rdata_stable: assert property (@(posedge clk) disable iff (rst)
        o_rvalid && !i_rready |=> $stable(o_rdata));

endmodule

// File: hw/dmem_pkg.sv
package dmem_pkg;

    localparam int DATA_W    = 32;
    localparam int MEM_BYTES = 64;
    localparam int ADDR_W    = 6;                    // Byte address, wraps at MEM_BYTES
    localparam int LANES     = 4;                    // Banks, also bytes per word
    localparam int LANE_W    = 2;
    localparam int ROW_W     = 4;
    localparam int ROWS      = MEM_BYTES / LANES;    // Depth of each byte bank

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Slave FSM encoding
    localparam int         STATE_W  = 2;
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_WRESP = 2'd1;          // BVALID pending
    localparam logic [1:0] ST_RRESP = 2'd2;          // RVALID pending

    // One data word, seen whole on the bus side and as bytes on the bank side.
    // Byte 0 is the least significant, which gives little-endian order.
    typedef union packed {
        logic [DATA_W-1:0]       word;
        logic [LANES-1:0][7:0]   bytes;
    } dmem_word_u;

endpackage
